// ==== list.f ====
rvPkg.sv
rvFetch.sv
rvRegFile.sv
rvDecode.sv
rvExecute.sv
rvMemory.sv
rvCore.sv
tbClock.sv
tbCoreAsserts.sv
tbCore.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  # core, package first
  - rvPkg.sv
  - rvFetch.sv
  - rvRegFile.sv
  - rvDecode.sv
  - rvExecute.sv
  - rvMemory.sv
  - rvCore.sv

  # testbench
  - target: simulation
    files:
      - tbClock.sv
      - tbCoreAsserts.sv
      - tbCore.sv

// ==== tbCore.sv ====
// testbench for the rv32i pipeline core with cache models, program table and store checker
`timescale 1ns/1ps

module tbCore;
    import rvPkg::*;

    localparam int STORE_TIMEOUT = 200;
    localparam int RESET_TIMEOUT = 10;
    localparam int IDLE_CYCLES   = 50;
    localparam int STALL_FROM    = 14;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    logic      clk;
    logic      rst_n;
    pcIdxT     icacheAddr;
    logic      icacheStall;
    wordT      icacheRdata;
    dcacheReqT dcacheReq;
    logic      dcacheStall;
    wordT      dcacheRdata;
    logic      stallOn = 1'b0;

    wordT      imem [128];
    wordT      dmem [64];
    wordT      progInst [128];
    logic      progHasStore [128];
    wordAddrT  progAddr [128];
    wordT      progData [128];
    int        numRows = 0;
    wordAddrT  storeAddrQ [$];
    wordT      storeDataQ [$];

    tbClock clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rvCore #(
        .RESET_PC (32'h0000_0000)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .icacheAddr  (icacheAddr),
        .icacheStall (icacheStall),
        .icacheRdata (icacheRdata),
        .dcacheReq   (dcacheReq),
        .dcacheStall (dcacheStall),
        .dcacheRdata (dcacheRdata)
    );

    bind rvCore tbCoreAsserts asserts_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dcacheReq   (dcacheReq),
        .dcacheStall (dcacheStall)
    );

    // ========================================
    // cache models
    // ========================================
    // word index is the halfword index shifted by one
    assign icacheRdata = imem[icacheAddr[7:1]];
    assign dcacheRdata = dmem[dcacheReq.addr[5:0]];

    always @(posedge clk) begin
        if (rst_n && dcacheReq.wen && !dcacheStall) begin
            dmem[dcacheReq.addr[5:0]] <= dcacheReq.wdata;
        end
        // store leaves the pipeline only when neither port stalls
        if (rst_n && dcacheReq.wen && !dcacheStall && !icacheStall) begin
            storeAddrQ.push_back(dcacheReq.addr);
            storeDataQ.push_back(dcacheReq.wdata);
        end
    end

    // each port stalls about one cycle in four once enabled
    initial begin
        void'($urandom(89));
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        forever begin
            @(negedge clk);
            icacheStall = stallOn && ($urandom_range(3) == 0);
            dcacheStall = stallOn && ($urandom_range(3) == 0);
        end
    end

    // ========================================
    // instruction encoding, RV32I formats
    // ========================================
    function automatic wordT aluReg(input logic [6:0] f7, input logic [2:0] f3,
                                    input regIdxT rd, input regIdxT rs1, input regIdxT rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic wordT aluImm(input logic [2:0] f3, input regIdxT rd, input regIdxT rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic wordT loadWord(input regIdxT rd, input regIdxT rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic wordT storeWord(input regIdxT rs2, input regIdxT rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic wordT branch(input logic [2:0] f3, input regIdxT rs1, input regIdxT rs2,
                                    input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic plainRow(input wordT inst);
        progInst[numRows]     = inst;
        progHasStore[numRows] = 1'b0;
        progAddr[numRows]     = '0;
        progData[numRows]     = '0;
        numRows++;
    endtask

    task automatic storeRow(input wordT inst, input wordAddrT addr, input wordT data);
        progInst[numRows]     = inst;
        progHasStore[numRows] = 1'b1;
        progAddr[numRows]     = addr;
        progData[numRows]     = data;
        numRows++;
    endtask

    // ========================================
    // program table where x1 is 100 and x2 is -7
    // ========================================
    task automatic buildProgram();
        plainRow(aluImm(F3_ADD, 1, 0, 12'd100));
        plainRow(aluImm(F3_ADD, 2, 0, 12'hFF9));
        plainRow(aluReg(F7_BASE, F3_ADD, 3, 1, 2));
        storeRow(storeWord(3, 0, 12'd128), 30'd32, 32'h0000_005D);
        plainRow(aluReg(F7_ALT, F3_ADD, 4, 1, 2));
        storeRow(storeWord(4, 0, 12'd132), 30'd33, 32'h0000_006B);
        plainRow(aluReg(F7_BASE, F3_SLT, 5, 2, 1));
        plainRow(aluReg(F7_BASE, F3_SLT, 6, 1, 2));
        storeRow(storeWord(5, 0, 12'd136), 30'd34, 32'h0000_0001);
        storeRow(storeWord(6, 0, 12'd140), 30'd35, 32'h0000_0000);
        plainRow(aluReg(F7_BASE, F3_XOR, 7, 1, 2));
        plainRow(aluReg(F7_BASE, F3_OR, 8, 1, 2));
        plainRow(aluReg(F7_BASE, F3_AND, 9, 1, 2));
        storeRow(storeWord(7, 0, 12'd144), 30'd36, 32'hFFFF_FF9D);
        storeRow(storeWord(8, 0, 12'd148), 30'd37, 32'hFFFF_FFFD);
        storeRow(storeWord(9, 0, 12'd152), 30'd38, 32'h0000_0060);
        plainRow(aluImm(F3_ADD, 10, 0, 12'd4));
        plainRow(aluReg(F7_BASE, F3_SLL, 11, 2, 10));
        plainRow(aluReg(F7_BASE, F3_SR, 12, 2, 10));
        plainRow(aluReg(F7_ALT, F3_SR, 13, 2, 10));
        storeRow(storeWord(11, 0, 12'd156), 30'd39, 32'hFFFF_FF90);
        storeRow(storeWord(12, 0, 12'd160), 30'd40, 32'h0FFF_FFFF);
        storeRow(storeWord(13, 0, 12'd164), 30'd41, 32'hFFFF_FFFF);
        plainRow(aluImm(F3_SLT, 14, 2, 12'hFFA));
        plainRow(aluImm(F3_XOR, 15, 1, 12'h0F0));
        plainRow(aluImm(F3_OR, 16, 1, 12'h101));
        plainRow(aluImm(F3_AND, 17, 2, 12'h7F0));
        storeRow(storeWord(14, 0, 12'd168), 30'd42, 32'h0000_0001);
        storeRow(storeWord(15, 0, 12'd172), 30'd43, 32'h0000_0094);
        storeRow(storeWord(16, 0, 12'd176), 30'd44, 32'h0000_0165);
        storeRow(storeWord(17, 0, 12'd180), 30'd45, 32'h0000_07F0);
        plainRow(aluImm(F3_SLL, 18, 1, 12'h003));
        plainRow(aluImm(F3_SR, 19, 2, 12'h01C));
        plainRow(aluImm(F3_SR, 20, 2, 12'h401));
        storeRow(storeWord(18, 0, 12'd184), 30'd46, 32'h0000_0320);
        storeRow(storeWord(19, 0, 12'd188), 30'd47, 32'h0000_000F);
        storeRow(storeWord(20, 0, 12'd192), 30'd48, 32'hFFFF_FFFC);
        // dependent chain through EX/MEM and writeback
        plainRow(aluImm(F3_ADD, 21, 1, 12'd1));
        plainRow(aluImm(F3_ADD, 21, 21, 12'd1));
        plainRow(aluReg(F7_BASE, F3_ADD, 22, 21, 21));
        storeRow(storeWord(22, 0, 12'd196), 30'd49, 32'h0000_00CC);
        // load-use on an ALU operand and on store data
        plainRow(loadWord(23, 0, 12'd20));
        plainRow(aluReg(F7_BASE, F3_ADD, 24, 23, 1));
        storeRow(storeWord(24, 0, 12'd200), 30'd50, 32'h5A00_0569);
        plainRow(loadWord(25, 0, 12'd24));
        storeRow(storeWord(25, 0, 12'd204), 30'd51, 32'h5A00_0606);
        plainRow(loadWord(26, 0, 12'd128));
        storeRow(storeWord(26, 0, 12'd208), 30'd52, 32'h0000_005D);
        plainRow(aluImm(F3_ADD, 0, 0, 12'd55));
        storeRow(storeWord(0, 0, 12'd212), 30'd53, 32'h0000_0000);
        // branches with offset 8 skip one instruction
        plainRow(branch(F3_BEQ, 1, 2, 13'd8));
        storeRow(storeWord(1, 0, 12'd216), 30'd54, 32'h0000_0064);
        plainRow(branch(F3_BNE, 1, 1, 13'd8));
        storeRow(storeWord(2, 0, 12'd220), 30'd55, 32'hFFFF_FFF9);
        plainRow(aluImm(F3_ADD, 27, 0, 12'd4));
        plainRow(branch(F3_BEQ, 27, 10, 13'd8));
        plainRow(storeWord(1, 0, 12'd224));
        storeRow(storeWord(27, 0, 12'd224), 30'd56, 32'h0000_0004);
        plainRow(aluImm(F3_ADD, 28, 27, 12'd96));
        plainRow(branch(F3_BNE, 28, 1, 13'd8));
        storeRow(storeWord(28, 0, 12'd228), 30'd57, 32'h0000_0064);
        plainRow(branch(F3_BNE, 28, 0, 13'd8));
        plainRow(storeWord(0, 0, 12'd232));
        plainRow(loadWord(29, 0, 12'd28));
        plainRow(branch(F3_BNE, 29, 0, 13'd8));
        plainRow(storeWord(29, 0, 12'd232));
        storeRow(storeWord(29, 0, 12'd236), 30'd59, 32'h5A00_0707);
        plainRow(branch(F3_BEQ, 0, 0, 13'd0));
    endtask

    // ========================================
    // checks
    // ========================================
    task automatic stopRun(input string why);
        $display("TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic checkStoreAddr(input wordAddrT got, input wordAddrT exp, input int idx);
        if (got !== exp) begin
            $display("ERROR at %0t: store %0d word address 0x%08h, expected 0x%08h",
                     $time, idx, got, exp);
            stopRun("store address mismatch");
        end
    endtask

    task automatic checkStoreData(input wordT got, input wordT exp, input int idx);
        if (got !== exp) begin
            $display("ERROR at %0t: store %0d data 0x%08h, expected 0x%08h",
                     $time, idx, got, exp);
            stopRun("store data mismatch");
        end
    endtask

    task automatic checkEnables(input dcacheReqT req);
        if (req.ren !== 1'b0 || req.wen !== 1'b0) begin
            $display("ERROR at %0t: data-cache enables ren=%b wen=%b, expected both low",
                     $time, req.ren, req.wen);
            stopRun("data-cache request active while the core should be idle");
        end
    endtask

    // bound assertions on the data-cache port
    always @(negedge clk) begin
        if (dut_i.asserts_i.failCount != 0) begin
            stopRun("bound assertions failed on the data-cache port");
        end
    end

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            stopRun("reset was never released");
        end
    endtask

    task automatic waitForStore(output wordAddrT addr, output wordT data);
        int cycles;
        cycles = 0;
        while (storeAddrQ.size() == 0 && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (storeAddrQ.size() == 0) begin
            stopRun("timed out waiting for a store at the data-cache port");
        end else begin
            addr = storeAddrQ.pop_front();
            data = storeDataQ.pop_front();
        end
    endtask

    task automatic watchIdle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            checkEnables(dcacheReq);
        end
        if (storeAddrQ.size() != 0) begin
            stopRun("a store reached the data cache after the last expected one");
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        int       storeIdx;
        wordAddrT gotAddr;
        wordT     gotData;
        buildProgram();
        for (int i = 0; i < 128; i++) begin
            imem[i] = (i < numRows) ? progInst[i] : NOP_INST;
        end
        // fill depends on the whole word address
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'h5A00_0000 | (wordT'(i) << 8) | wordT'(i);
        end
        waitForReset();
        storeIdx = 0;
        for (int row = 0; row < numRows; row++) begin
            if (progHasStore[row]) begin
                // second half runs with random cache stalls
                if (storeIdx == STALL_FROM) begin
                    stallOn <= 1'b1;
                end
                waitForStore(gotAddr, gotData);
                checkStoreAddr(gotAddr, progAddr[row], storeIdx);
                checkStoreData(gotData, progData[row], storeIdx);
                storeIdx++;
            end
        end
        watchIdle(IDLE_CYCLES);
        if (dut_i.asserts_i.failCount != 0) begin
            $display("ERROR at %0t: %0d assertion failures on the data-cache port",
                     $time, dut_i.asserts_i.failCount);
            stopRun("bound assertions failed during the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== tbCoreAsserts.sv ====
// bound checks on the data-cache request port of the pipeline core
`timescale 1ns/1ps

module tbCoreAsserts (
    input logic              clk,
    input logic              rst_n,
    input rvPkg::dcacheReqT  dcacheReq,
    input logic              dcacheStall
);

    // count of failed assertions
    int failCount = 0;

    // read and write never go out together
    exclusiveEnables: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheReq.ren && dcacheReq.wen))
    else begin
        failCount++;
        $error("data-cache read and write enables are high in the same cycle");
    end

    // a stalled request must be held unchanged
    heldWhileStalled: assert property (@(posedge clk) disable iff (!rst_n)
        dcacheStall |=> $stable(dcacheReq))
    else begin
        failCount++;
        $error("data-cache request changed while the port was stalled");
    end

    // pipeline is empty right after reset
    quietAfterReset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!dcacheReq.ren && !dcacheReq.wen))
    else begin
        failCount++;
        $error("data-cache enable high in the first cycle after reset");
    end

endmodule

// ==== tbClock.sv ====
// testbench clock and reset generator with a 20 ns period and reset held for two cycles
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== rvCore.sv ====
// five-stage rv32i pipeline core top level with instruction-cache and data-cache ports
`timescale 1ns/1ps

module rvCore #(
    parameter rvPkg::wordT RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    output rvPkg::pcIdxT      icacheAddr,
    input  logic              icacheStall,
    input  rvPkg::wordT       icacheRdata,
    output rvPkg::dcacheReqT  dcacheReq,
    input  logic              dcacheStall,
    input  rvPkg::wordT       dcacheRdata
);
    import rvPkg::*;

    logic     freeze;
    logic     holdFetch;
    redirectT redirect;
    wordT     ifInst;
    wordT     ifPc;
    regIdxT   rs1;
    regIdxT   rs2;
    wordT     rdata1;
    wordT     rdata2;
    idExT     idEx;
    exMemT    exMem;
    fwdT      exFwd;
    fwdT      wbFwd;

    rvFetch #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .icacheStall (icacheStall),
        .dcacheStall (dcacheStall),
        .icacheRdata (icacheRdata),
        .holdFetch   (holdFetch),
        .redirect    (redirect),
        .icacheAddr  (icacheAddr),
        .freeze      (freeze),
        .ifInst      (ifInst),
        .ifPc        (ifPc)
    );

    rvDecode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .freeze    (freeze),
        .ifInst    (ifInst),
        .ifPc      (ifPc),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .rs1       (rs1),
        .rs2       (rs2),
        .exFwd     (exFwd),
        .wbFwd     (wbFwd),
        .holdFetch (holdFetch),
        .redirect  (redirect),
        .idEx      (idEx)
    );

    // writeback port is the MEM/WB record
    rvRegFile regFile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .freeze (freeze),
        .wb     (wbFwd),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rvExecute execute_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .freeze (freeze),
        .idEx   (idEx),
        .wbFwd  (wbFwd),
        .exMem  (exMem),
        .exFwd  (exFwd)
    );

    rvMemory memory_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .freeze      (freeze),
        .exMem       (exMem),
        .dcacheRdata (dcacheRdata),
        .dcacheReq   (dcacheReq),
        .wbFwd       (wbFwd)
    );

endmodule

// ==== rvMemory.sv ====
// memory and writeback stage with data-cache request, MEM/WB register and writeback select
`timescale 1ns/1ps

module rvMemory (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              freeze,
    input  rvPkg::exMemT      exMem,
    input  rvPkg::wordT       dcacheRdata,
    output rvPkg::dcacheReqT  dcacheReq,
    output rvPkg::fwdT        wbFwd
);

    // request comes straight out of EX/MEM and is held there on a stall
    assign dcacheReq.ren   = exMem.ctrl.memRead;
    assign dcacheReq.wen   = exMem.ctrl.memWrite;
    assign dcacheReq.addr  = exMem.aluOut[31:2];
    assign dcacheReq.wdata = exMem.storeData;

    // read data arrives in the same cycle and is selected before MEM/WB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbFwd <= '0;
        end else if (!freeze) begin
            wbFwd.regWrite <= exMem.ctrl.regWrite;
            wbFwd.memRead  <= exMem.ctrl.memRead;
            wbFwd.rd       <= exMem.rd;
            wbFwd.data     <= exMem.ctrl.memToReg ? dcacheRdata : exMem.aluOut;
        end
    end

endmodule

// ==== rvExecute.sv ====
// execute stage with EX forwarding, operand select, ALU and EX/MEM register
`timescale 1ns/1ps

module rvExecute (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          freeze,
    input  rvPkg::idExT   idEx,
    input  rvPkg::fwdT    wbFwd,
    output rvPkg::exMemT  exMem,
    output rvPkg::fwdT    exFwd
);
    import rvPkg::*;

    wordT  opA;
    wordT  opB;
    wordT  aluB;
    wordT  aluOut;
    exMemT exMemD;

    // EX/MEM result offered back to decode and to this stage
    assign exFwd.regWrite = exMem.ctrl.regWrite;
    assign exFwd.memRead  = exMem.ctrl.memRead;
    assign exFwd.rd       = exMem.rd;
    assign exFwd.data     = exMem.aluOut;

    // ======================================
    // operands
    // ======================================
    assign opA  = fwdOperand(exFwd, wbFwd, idEx.rs1, idEx.op1);
    assign opB  = fwdOperand(exFwd, wbFwd, idEx.rs2, idEx.op2);
    assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

    // ======================================
    // ALU
    // ======================================
    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: aluOut = opA + aluB;
            ALU_SUB: aluOut = opA - aluB;
            ALU_SLT: aluOut = ($signed(opA) < $signed(aluB)) ? 32'd1 : 32'd0;
            ALU_XOR: aluOut = opA ^ aluB;
            ALU_OR:  aluOut = opA | aluB;
            ALU_AND: aluOut = opA & aluB;
            // shift amount is the low five bits in both R and I forms
            ALU_SLL: aluOut = opA << aluB[4:0];
            ALU_SRL: aluOut = opA >> aluB[4:0];
            ALU_SRA: aluOut = $signed(opA) >>> aluB[4:0];
            default: aluOut = opA + aluB;
        endcase
    end

    always_comb begin
        exMemD.ctrl      = idEx.valid ? idEx.ctrl : '0;
        exMemD.aluOut    = aluOut;
        exMemD.storeData = opB;
        exMemD.rd        = idEx.rd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem <= '0;
        end else if (!freeze) begin
            exMem <= exMemD;
        end
    end

endmodule

// ==== rvDecode.sv ====
// decode stage with control decode, immediates, ID forwarding, branch resolve, hazards and ID/EX
`timescale 1ns/1ps

module rvDecode (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            freeze,
    input  rvPkg::wordT     ifInst,
    input  rvPkg::wordT     ifPc,
    input  rvPkg::wordT     rdata1,
    input  rvPkg::wordT     rdata2,
    output rvPkg::regIdxT   rs1,
    output rvPkg::regIdxT   rs2,
    input  rvPkg::fwdT      exFwd,
    input  rvPkg::fwdT      wbFwd,
    output logic            holdFetch,
    output rvPkg::redirectT redirect,
    output rvPkg::idExT     idEx
);
    import rvPkg::*;

    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_I      = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       isR;
    logic       isI;
    logic       isLoad;
    logic       isStore;
    logic       isBranch;
    logic       usesRs1;
    logic       usesRs2;
    ctrlT       ctrl;
    aluOpT      aluOp;
    wordT       immI;
    wordT       immS;
    wordT       immB;
    wordT       op1;
    wordT       op2;
    logic       idExHit;
    logic       exMemHit;
    logic       loadUse;
    logic       branchHazard;
    logic       stall;
    logic       branchEq;
    idExT       idExD;

    // alt selects sub or sra
    function automatic aluOpT decodeAluOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode   = ifInst[6:0];
    assign funct3   = ifInst[14:12];
    assign rs1      = ifInst[19:15];
    assign rs2      = ifInst[24:20];
    assign isR      = (opcode == OPC_R);
    assign isI      = (opcode == OPC_I);
    assign isLoad   = (opcode == OPC_LOAD);
    assign isStore  = (opcode == OPC_STORE);
    assign isBranch = (opcode == OPC_BRANCH);
    assign usesRs1  = isR | isI | isLoad | isStore | isBranch;
    assign usesRs2  = isR | isStore | isBranch;

    // ======================================
    // control and immediates
    // ======================================
    always_comb begin
        ctrl  = '0;
        aluOp = ALU_ADD;
        if (isR) begin
            ctrl.regWrite = 1'b1;
            aluOp         = decodeAluOp(funct3, ifInst[30]);
        end else if (isI) begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            // bit 30 is part of the addi immediate and only srai reads it
            aluOp         = decodeAluOp(funct3, funct3 == 3'b101 && ifInst[30]);
        end else if (isLoad) begin
            ctrl.regWrite = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluSrc   = 1'b1;
        end else if (isStore) begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
        end
    end

    assign immI = {{20{ifInst[31]}}, ifInst[31:20]};
    assign immS = {{20{ifInst[31]}}, ifInst[31:25], ifInst[11:7]};
    assign immB = {{19{ifInst[31]}}, ifInst[31], ifInst[7], ifInst[30:25], ifInst[11:8], 1'b0};

    assign op1 = fwdOperand(exFwd, wbFwd, rs1, rdata1);
    assign op2 = fwdOperand(exFwd, wbFwd, rs2, rdata2);

    // ======================================
    // hazards and branch resolve
    // ======================================
    assign idExHit  = idEx.rd != '0 &&
                      ((usesRs1 && idEx.rd == rs1) || (usesRs2 && idEx.rd == rs2));
    assign exMemHit = exFwd.rd != '0 &&
                      ((usesRs1 && exFwd.rd == rs1) || (usesRs2 && exFwd.rd == rs2));

    assign loadUse      = idEx.ctrl.memRead && idExHit;
    // compare happens here, so the operand must already sit in EX/MEM as an ALU result
    assign branchHazard = isBranch &&
                          ((idEx.ctrl.regWrite && idExHit) ||
                           (exFwd.regWrite && exFwd.memRead && exMemHit));
    assign stall        = loadUse | branchHazard;
    assign holdFetch    = stall;

    assign branchEq = (op1 == op2);

    assign redirect.taken  = isBranch && !stall &&
                             ((funct3 == 3'b000 && branchEq) || (funct3 == 3'b001 && !branchEq));
    assign redirect.target = ifPc + immB;

    always_comb begin
        idExD.ctrl  = ctrl;
        idExD.aluOp = aluOp;
        idExD.pc    = ifPc;
        idExD.op1   = op1;
        idExD.op2   = op2;
        idExD.imm   = isStore ? immS : immI;
        idExD.rs1   = rs1;
        idExD.rs2   = rs2;
        idExD.rd    = ifInst[11:7];
        idExD.valid = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else if (!freeze) begin
            // bubble while the instruction waits in decode
            idEx <= stall ? '0 : idExD;
        end
    end

endmodule

// ==== rvRegFile.sv ====
// integer register file with 31 writable registers and x0 tied to zero
`timescale 1ns/1ps

module rvRegFile (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          freeze,
    input  rvPkg::fwdT    wb,
    input  rvPkg::regIdxT rs1,
    input  rvPkg::regIdxT rs2,
    output rvPkg::wordT   rdata1,
    output rvPkg::wordT   rdata2
);
    import rvPkg::*;

    wordT regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (!freeze && wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // no bypass here since decode forwards the writeback value itself
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rvFetch.sv ====
// fetch stage with program counter, instruction-cache address, IF/ID register and pipeline freeze
`timescale 1ns/1ps

module rvFetch #(
    parameter rvPkg::wordT RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            icacheStall,
    input  logic            dcacheStall,
    input  rvPkg::wordT     icacheRdata,
    input  logic            holdFetch,
    input  rvPkg::redirectT redirect,
    output rvPkg::pcIdxT    icacheAddr,
    output logic            freeze,
    output rvPkg::wordT     ifInst,
    output rvPkg::wordT     ifPc
);
    import rvPkg::*;

    wordT pcQ;

    // either cache port stops every stage
    assign freeze = icacheStall | dcacheStall;

    // halfword index as bit 0 of the pc is always zero
    assign icacheAddr = pcQ[31:1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcQ    <= RESET_PC;
            ifInst <= NOP_INST;
            ifPc   <= '0;
        end else if (!freeze && !holdFetch) begin
            if (redirect.taken) begin
                // fetched word is on the wrong path
                pcQ    <= redirect.target;
                ifInst <= NOP_INST;
            end else begin
                pcQ    <= pcQ + 32'd4;
                ifInst <= icacheRdata;
            end
            ifPc <= pcQ;
        end
    end

endmodule

// ==== rvPkg.sv ====
// rv32i core package with shared widths, ALU operations, pipeline records and forwarding helper
package rvPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [29:0] wordAddrT;
    typedef logic [30:0] pcIdxT;

    // ALU operation, chosen in decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } aluOpT;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrc;
    } ctrlT;

    typedef struct packed {
        ctrlT   ctrl;
        aluOpT  aluOp;
        wordT   pc;
        wordT   op1;
        wordT   op2;
        wordT   imm;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        logic   valid;
    } idExT;

    typedef struct packed {
        ctrlT   ctrl;
        wordT   aluOut;
        wordT   storeData;
        regIdxT rd;
    } exMemT;

    // result that a later stage can hand back to decode or execute
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        regIdxT rd;
        wordT   data;
    } fwdT;

    typedef struct packed {
        logic taken;
        wordT target;
    } redirectT;

    typedef struct packed {
        logic     ren;
        logic     wen;
        wordAddrT addr;
        wordT     wdata;
    } dcacheReqT;

    // addi x0, x0, 0
    localparam wordT NOP_INST = 32'h0000_0013;

    // EX/MEM wins over writeback, x0 never matches, a load in EX/MEM has no data yet
    function automatic wordT fwdOperand(input fwdT exSrc, input fwdT wbSrc, input regIdxT rs,
                                        input wordT regVal);
        if (exSrc.regWrite && !exSrc.memRead && exSrc.rd != '0 && exSrc.rd == rs) begin
            return exSrc.data;
        end
        if (wbSrc.regWrite && wbSrc.rd != '0 && wbSrc.rd == rs) begin
            return wbSrc.data;
        end
        return regVal;
    endfunction

endpackage
